// ==== verilog/dbg_pkg.sv ====
// Opcodes, command layout and byte stream types shared by the debugger RTL and its testbench
`default_nettype none

package dbg_pkg;

	// ********************
	// Command opcodes
	// ********************

	// Four ASCII characters at the head of each 8-byte command copy
	typedef enum logic [31:0] {
		OP_READ_BYTES  = 32'h5265_6164, // "Read", 1 to 256 bytes from host memory
		OP_READ_BURST  = 32'h5265_6150, // "ReaP", (size+1)*256 bytes from host memory
		OP_WRITE_BYTES = 32'h5772_6974, // "Writ", 1 to 256 bytes into host memory
		OP_WRITE_BURST = 32'h5772_6950, // "WriP", (size+1)*256 bytes into host memory
		OP_SET_PORTS   = 32'h5365_7450  // "SetP", latch outputs and report inputs
	} opcode_e;

	// ********************
	// Command body
	// ********************

	// Memory operations carry a start address and a size code
	typedef struct packed {
		logic [23:0] addr; // First byte address, upper bits ignored beyond ADDR_SIZE
		logic [7:0]  size; // Byte count minus one, or page count minus one for bursts
	} mem_body_t;

	// Set ports reuses the same four bytes as the new output values
	typedef struct packed {
		logic [7:0] out0; // Sits where the top address byte would be
		logic [7:0] out1;
		logic [7:0] out2;
		logic [7:0] out3; // Sits where the size code would be
	} port_body_t;

	// The body is read one way or the other depending on the opcode
	typedef union packed {
		mem_body_t  mem;
		port_body_t ports;
	} cmd_body_u;

	// One verified command, opcode in the first four bytes received
	typedef struct packed {
		opcode_e   op;
		cmd_body_u body;
	} cmd_t;

	// One byte on either stream, valid for a single cycle
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} byte_beat_t;

	// Header ahead of the two command copies
	localparam int HDR_FF_COUNT = 2; // Leading 0xFF bytes
	localparam int HDR_00_COUNT = 6; // 0x00 bytes that follow them

	// Byte counter runs down to minus one, so the top bit flags the end
	localparam int COUNT_W = 17;

endpackage

`default_nettype wire

// ==== verilog/cmd_framer.sv ====
// Command framer: finds the header and two matching copies in forwarded bytes, emits one command
`default_nettype none

module cmd_framer import dbg_pkg::*; (
	input  logic       clk,
	input  logic       cmd_rst,
	input  byte_beat_t fwd,       // Bytes received while the sequencer is idle
	output cmd_t       cmd,       // Second copy of the matched command
	output logic       cmd_valid  // One cycle pulse after the completing byte
);

	// ********************
	// Window and counters
	// ********************

	logic [127:0] window;     // Newest byte in the low eight bits
	logic [127:0] window_nxt; // Window after the current byte shifts in
	logic [3:0]   ff_cnt;     // Run of 0xFF bytes that have left the window
	logic [3:0]   zz_cnt;     // Run of 0x00 bytes that have left the window
	logic [3:0]   ff_nxt;
	logic [3:0]   zz_nxt;
	logic [7:0]   leaving;    // Oldest byte, pushed out by the new one
	logic         hit;        // The new byte completes a valid frame

	always_comb begin
		leaving    = window[127:120];
		window_nxt = {window[119:0], fwd.data}; // Shift by one byte

		// Zeros counted in a run, anything else breaks it
		if (leaving == 8'h00) begin
			zz_nxt = zz_cnt + {3'b000, zz_cnt != 4'hF}; // Saturates at 15
		end else begin
			zz_nxt = 4'h0;
		end

		// Zeros after the 0xFF run leave the 0xFF count alone
		if (leaving == 8'hFF) begin
			ff_nxt = ff_cnt + {3'b000, ff_cnt != 4'hF};
		end else if (leaving != 8'h00) begin
			ff_nxt = 4'h0;
		end else begin
			ff_nxt = ff_cnt;
		end

		// Header must be exact and both copies identical
		hit = fwd.valid
			&& ff_nxt == 4'(HDR_FF_COUNT)
			&& zz_nxt == 4'(HDR_00_COUNT)
			&& window_nxt[127:64] == window_nxt[63:0];
	end

	always_ff @(posedge clk) begin
		if (cmd_rst) begin
			window    <= '0;
			ff_cnt    <= 4'h0;
			zz_cnt    <= 4'h0;
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= hit;
			if (hit) begin
				// Start over so the same frame cannot fire twice
				window <= '0;
				ff_cnt <= 4'h0;
				zz_cnt <= 4'h0;
			end else if (fwd.valid) begin
				window <= window_nxt;
				ff_cnt <= ff_nxt;
				zz_cnt <= zz_nxt;
			end
		end
	end

	// Command payload, only looked at while cmd_valid is high
	always_ff @(posedge clk) begin
		if (hit) begin
			cmd <= cmd_t'(window_nxt[63:0]);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/host_mem_port.sv ====
// Host memory port: address counter plus the held read request and one-cycle write strobe
`default_nettype none

module host_mem_port #(
	parameter int ADDR_SIZE = 20 // Host address width, 24 at most
) (
	input  logic                 clk,
	input  logic                 cmd_rst,
	input  logic                 load,        // Take load_addr as the next address
	input  logic                 rd_start,    // Begin one byte read
	input  logic                 wr_start,    // Write wr_byte on the next cycle
	input  logic [23:0]          load_addr,
	input  logic [7:0]           wr_byte,
	input  logic                 host_rd_rdy,
	input  logic [7:0]           host_rdata,
	output logic                 rd_done,     // Captured byte is in rd_byte
	output logic [7:0]           rd_byte,
	output logic                 host_rd_req,
	output logic                 host_wr_ena,
	output logic [ADDR_SIZE-1:0] host_addr,
	output logic [7:0]           host_wdata
);

	logic                 rd_hit; // Request meets ready in this cycle
	logic [ADDR_SIZE-1:0] addr_q;

	assign rd_hit    = host_rd_req && host_rd_rdy;
	assign host_addr = addr_q;

	always_ff @(posedge clk) begin
		if (cmd_rst) begin
			addr_q      <= '0;
			host_rd_req <= 1'b0;
			host_wr_ena <= 1'b0;
			rd_done     <= 1'b0;
		end else begin
			// Request stays up until the host answers
			if (rd_start) begin
				host_rd_req <= 1'b1;
			end else if (rd_hit) begin
				host_rd_req <= 1'b0;
			end
			rd_done     <= rd_hit;   // Data is registered by now
			host_wr_ena <= wr_start; // Single cycle strobe

			// ********************
			// Address counter
			// ********************
			if (load) begin
				addr_q <= load_addr[ADDR_SIZE-1:0]; // Upper command bits dropped
			end else if (rd_hit || host_wr_ena) begin
				addr_q <= addr_q + 1'b1; // Step past each finished access
			end
		end
	end

	// Data registers carry no control meaning
	always_ff @(posedge clk) begin
		if (rd_hit) begin
			rd_byte <= host_rdata;
		end
		if (wr_start) begin
			host_wdata <= wr_byte;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/port_bank.sv ====
// Utility port bank: output port registers, input snapshot and the status bytes sent back
`default_nettype none

module port_bank import dbg_pkg::*; #(
	parameter int ADDR_SIZE = 20 // Reported as the fifth status byte
) (
	input  logic       clk,
	input  logic       cmd_rst,
	input  logic       set,         // Set ports command accepted
	input  port_body_t values,      // New output values
	input  logic [7:0] in0,
	input  logic [7:0] in1,
	input  logic [7:0] in2,
	input  logic [7:0] in3,
	input  logic [2:0] index,       // Which status byte to send
	output logic [7:0] out0,
	output logic [7:0] out1,
	output logic [7:0] out2,
	output logic [7:0] out3,
	output logic [7:0] status_byte
);

	logic [7:0] in_cap [4]; // Inputs as they stood at the command

	always_ff @(posedge clk) begin
		if (cmd_rst) begin
			out0 <= 8'h00;
			out1 <= 8'h00;
			out2 <= 8'h00;
			out3 <= 8'h00;
		end else if (set) begin
			out0 <= values.out0;
			out1 <= values.out1;
			out2 <= values.out2;
			out3 <= values.out3;
		end
	end

	// Snapshot taken on the same edge as the outputs change
	always_ff @(posedge clk) begin
		if (set) begin
			in_cap[0] <= in0;
			in_cap[1] <= in1;
			in_cap[2] <= in2;
			in_cap[3] <= in3;
		end
	end

	// Four captured inputs, then the address width
	always_comb begin
		case (index)
			3'd0:    status_byte = in_cap[0];
			3'd1:    status_byte = in_cap[1];
			3'd2:    status_byte = in_cap[2];
			3'd3:    status_byte = in_cap[3];
			3'd4:    status_byte = 8'(ADDR_SIZE);
			default: status_byte = 8'h00; // Never sent
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/transfer_sequencer.sv ====
// Operation sequencer: runs read, write and set ports, and owns both stream credits
`default_nettype none

module transfer_sequencer import dbg_pkg::*; #(
	parameter int TX_CREDITS = 2 // Transmit credits held after reset
) (
	input  logic       clk,
	input  logic       cmd_rst,
	input  byte_beat_t rx,
	input  logic       tx_credit,   // Host frees one transmit slot
	input  cmd_t       cmd,
	input  logic       cmd_valid,
	input  logic       rd_done,
	input  logic [7:0] rd_byte,
	input  logic [7:0] status_byte,
	output logic       rx_credit,   // One receive byte consumed
	output byte_beat_t tx,
	output byte_beat_t fwd,         // Idle bytes toward the framer
	output logic       load,
	output logic       rd_start,
	output logic       wr_start,
	output logic [23:0] load_addr,
	output logic [7:0] wr_byte,
	output logic       set,
	output port_body_t values,
	output logic [2:0] index
);

	typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE, ST_PORTS} state_e;

	localparam int CW = $clog2(TX_CREDITS + 1);

	state_e             state;
	logic [COUNT_W-1:0] count;     // Bytes left minus one
	logic               done;      // Counter has gone below zero
	logic [CW-1:0]      tx_cnt;    // Transmit credits in hand
	logic               tx_ok;
	logic               rd_busy;   // Host read in flight
	logic               slot_full; // Write byte waiting for its echo credit
	logic [7:0]         slot_data;
	logic               held;      // Credit of the last idle byte not yet returned
	logic               ret_held;
	logic               read_go;
	logic               take;      // Move the slot byte to memory and tx
	logic               rd_issue;
	logic               port_send;
	logic               spend;     // A transmit beat is committed
	logic               tx_valid;
	logic [7:0]         tx_data;

	assign done  = count[COUNT_W-1];
	assign tx_ok = tx_cnt != '0;
	assign fwd   = '{valid: rx.valid && state == ST_IDLE, data: rx.data};
	assign tx    = '{valid: tx_valid, data: tx_data};

	// ********************
	// Command decode
	// ********************
	always_comb begin
		load    = 1'b0;
		set     = 1'b0;
		read_go = 1'b0;
		if (cmd_valid && state == ST_IDLE) begin
			case (cmd.op)
				OP_READ_BYTES, OP_READ_BURST: begin
					load    = 1'b1;
					read_go = 1'b1;
				end
				OP_WRITE_BYTES, OP_WRITE_BURST: load = 1'b1;
				OP_SET_PORTS:                   set  = 1'b1;
				default:                        load = 1'b0; // Unknown opcode is dropped
			endcase
		end
	end

	assign load_addr = cmd.body.mem.addr;
	assign values    = cmd.body.ports;

	// Reads and set ports keep the host's credit until they finish
	assign ret_held  = held && state == ST_IDLE && !read_go && !set;
	assign rd_issue  = state == ST_READ && !done && !rd_busy && tx_ok;
	assign take      = state == ST_WRITE && !done && slot_full && tx_ok;
	assign port_send = state == ST_PORTS && !done && tx_ok;
	assign spend     = rd_issue || take || port_send;
	assign rd_start  = rd_issue;
	assign wr_start  = take;
	assign wr_byte   = slot_data;
	assign index     = 3'd4 - count[2:0]; // Counts 4 down to 0 send index 0 up to 4

	always_ff @(posedge clk) begin
		if (cmd_rst) begin
			state     <= ST_IDLE;
			count     <= '0;
			tx_cnt    <= CW'(TX_CREDITS);
			rd_busy   <= 1'b0;
			slot_full <= 1'b0;
			held      <= 1'b0;
			rx_credit <= 1'b0;
			tx_valid  <= 1'b0;
		end else begin
			rx_credit <= ret_held || take;
			tx_valid  <= spend && !rd_issue || rd_done; // Read beats follow rd_done
			if (fwd.valid) begin
				held <= 1'b1;
			end else if (ret_held) begin
				held <= 1'b0;
			end

			// Credits are spent when a beat is committed
			if (tx_credit && !spend) begin
				tx_cnt <= tx_cnt + 1'b1;
			end else if (!tx_credit && spend) begin
				tx_cnt <= tx_cnt - 1'b1;
			end

			// ********************
			// Operation FSM
			// ********************
			case (state)
				ST_IDLE: begin
					if (cmd_valid) begin
						case (cmd.op)
							OP_READ_BYTES: begin
								count <= {{(COUNT_W - 8){1'b0}}, cmd.body.mem.size};
								state <= ST_READ;
							end
							OP_READ_BURST: begin
								count <= {{(COUNT_W - 16){1'b0}}, cmd.body.mem.size, 8'hFF};
								state <= ST_READ;
							end
							OP_WRITE_BYTES: begin
								count <= {{(COUNT_W - 8){1'b0}}, cmd.body.mem.size};
								state <= ST_WRITE;
							end
							OP_WRITE_BURST: begin
								count <= {{(COUNT_W - 16){1'b0}}, cmd.body.mem.size, 8'hFF};
								state <= ST_WRITE;
							end
							OP_SET_PORTS: begin
								count <= COUNT_W'(4); // Four inputs and the address width
								state <= ST_PORTS;
							end
							default: state <= ST_IDLE;
						endcase
					end
				end
				ST_READ: begin
					if (rd_issue) begin
						rd_busy <= 1'b1;
					end
					if (rd_done) begin
						rd_busy <= 1'b0;
						count   <= count - 1'b1;
					end
					if (done && !rd_busy) begin
						state <= ST_IDLE;
					end
				end
				ST_WRITE: begin
					if (rx.valid) begin
						slot_full <= 1'b1; // Only one byte can be outstanding
					end
					if (take) begin
						slot_full <= 1'b0;
						count     <= count - 1'b1;
					end
					if (done) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					if (port_send) begin
						count <= count - 1'b1;
					end
					if (done) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// Slot and outgoing data
	always_ff @(posedge clk) begin
		if (rx.valid && state == ST_WRITE) begin
			slot_data <= rx.data;
		end
		if (take) begin
			tx_data <= slot_data; // Echo leaves with host_wr_ena
		end else if (rd_done) begin
			tx_data <= rd_byte;
		end else if (port_send) begin
			tx_data <= status_byte;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/serial_debugger.sv ====
// Debugger top level: joins framer, sequencer, memory port and port bank to the outside streams
`default_nettype none

module serial_debugger import dbg_pkg::*; #(
	parameter int ADDR_SIZE  = 20, // Host address width, 24 at most
	parameter int TX_CREDITS = 2   // Transmit credits after reset
) (
	input  logic                 clk,
	input  logic                 cmd_rst,
	input  byte_beat_t           rx,          // Command and write data bytes
	output logic                 rx_credit,
	output byte_beat_t           tx,          // Read data, echoes and port status
	input  logic                 tx_credit,
	output logic                 host_rd_req,
	input  logic                 host_rd_rdy,
	output logic                 host_wr_ena,
	output logic [ADDR_SIZE-1:0] host_addr,
	output logic [7:0]           host_wdata,
	input  logic [7:0]           host_rdata,
	input  logic [7:0]           in0,
	input  logic [7:0]           in1,
	input  logic [7:0]           in2,
	input  logic [7:0]           in3,
	output logic [7:0]           out0,
	output logic [7:0]           out1,
	output logic [7:0]           out2,
	output logic [7:0]           out3
);

	// ********************
	// Internal wiring
	// ********************
	byte_beat_t  fwd;
	cmd_t        cmd;
	logic        cmd_valid;
	logic        load;
	logic        rd_start;
	logic        wr_start;
	logic [23:0] load_addr;
	logic [7:0]  wr_byte;
	logic        rd_done;
	logic [7:0]  rd_byte;
	logic        set;
	port_body_t  values;
	logic [2:0]  index;
	logic [7:0]  status_byte;

	cmd_framer framer0 (
		.clk       (clk),
		.cmd_rst   (cmd_rst),
		.fwd       (fwd),
		.cmd       (cmd),
		.cmd_valid (cmd_valid)
	);

	transfer_sequencer #(.TX_CREDITS(TX_CREDITS)) seq0 (
		.clk         (clk),
		.cmd_rst     (cmd_rst),
		.rx          (rx),
		.tx_credit   (tx_credit),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.rd_done     (rd_done),
		.rd_byte     (rd_byte),
		.status_byte (status_byte),
		.rx_credit   (rx_credit),
		.tx          (tx),
		.fwd         (fwd),
		.load        (load),
		.rd_start    (rd_start),
		.wr_start    (wr_start),
		.load_addr   (load_addr),
		.wr_byte     (wr_byte),
		.set         (set),
		.values      (values),
		.index       (index)
	);

	host_mem_port #(.ADDR_SIZE(ADDR_SIZE)) mem0 (
		.clk         (clk),
		.cmd_rst     (cmd_rst),
		.load        (load),
		.rd_start    (rd_start),
		.wr_start    (wr_start),
		.load_addr   (load_addr),
		.wr_byte     (wr_byte),
		.host_rd_rdy (host_rd_rdy),
		.host_rdata  (host_rdata),
		.rd_done     (rd_done),
		.rd_byte     (rd_byte),
		.host_rd_req (host_rd_req),
		.host_wr_ena (host_wr_ena),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata)
	);

	port_bank #(.ADDR_SIZE(ADDR_SIZE)) ports0 (
		.clk         (clk),
		.cmd_rst     (cmd_rst),
		.set         (set),
		.values      (values),
		.in0         (in0),
		.in1         (in1),
		.in2         (in2),
		.in3         (in3),
		.index       (index),
		.out0        (out0),
		.out1        (out1),
		.out2        (out2),
		.out3        (out3),
		.status_byte (status_byte)
	);

endmodule

`default_nettype wire

// ==== tests/serial_debugger_asserts.sv ====
// Protocol assertions bound into the debugger top level for stream credits and host handshakes
`default_nettype none

module serial_debugger_asserts import dbg_pkg::*; #(
	parameter int TX_CREDITS = 2 // Must match the DUT
) (
	input logic       clk,
	input logic       cmd_rst,
	input byte_beat_t rx,
	input byte_beat_t tx,
	input logic       rx_credit,
	input logic       tx_credit,
	input logic       host_rd_req,
	input logic       host_rd_rdy,
	input logic       host_wr_ena,
	input logic       set,
	input logic [7:0] out0,
	input logic [7:0] out1,
	input logic [7:0] out2,
	input logic [7:0] out3
);
	timeunit 1ns;
	timeprecision 1ps;

	int tx_avail; // Credits the host side believes the DUT holds
	int rx_owed;  // Received bytes whose credit is not back yet

	always_ff @(posedge clk) begin
		if (cmd_rst) begin
			tx_avail <= TX_CREDITS;
			rx_owed  <= 0;
		end else begin
			tx_avail <= tx_avail - int'(tx.valid) + int'(tx_credit);
			rx_owed  <= rx_owed + int'(rx.valid) - int'(rx_credit);
		end
	end

	// ********************
	// Handshake rules
	// ********************
	tx_needs_credit: assert property (@(posedge clk) disable iff (cmd_rst)
		tx.valid |-> tx_avail > 0) else $error("tx beat with no credit");

	rx_credit_bounded: assert property (@(posedge clk) disable iff (cmd_rst)
		rx_credit |-> rx_owed > 0) else $error("rx credit returned without a byte");

	rd_req_held: assert property (@(posedge clk) disable iff (cmd_rst)
		host_rd_req && !host_rd_rdy |=> host_rd_req) else $error("read request dropped early");

	wr_ena_single: assert property (@(posedge clk) disable iff (cmd_rst)
		host_wr_ena |=> !host_wr_ena) else $error("write strobe longer than one cycle");

	// Output ports move only on the edge right after an accepted set ports command
	ports_move_on_set: assert property (@(posedge clk) disable iff (cmd_rst)
		!$stable({out0, out1, out2, out3}) |-> $past(set)) else $error("ports changed without set");

endmodule

bind serial_debugger serial_debugger_asserts #(.TX_CREDITS(TX_CREDITS)) asrt0 (
	.clk         (clk),
	.cmd_rst     (cmd_rst),
	.rx          (rx),
	.tx          (tx),
	.rx_credit   (rx_credit),
	.tx_credit   (tx_credit),
	.host_rd_req (host_rd_req),
	.host_rd_rdy (host_rd_rdy),
	.host_wr_ena (host_wr_ena),
	.set         (set),
	.out0        (out0),
	.out1        (out1),
	.out2        (out2),
	.out3        (out3)
);

`default_nettype wire

// ==== tests/tb_serial_debugger.sv ====
// Testbench for the serial debugger: sends framed commands, models host memory and checks tx bytes
`default_nettype none

module tb_serial_debugger import dbg_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ADDR_SIZE  = 20;
	localparam int TX_CREDITS = 2;
	localparam int WAIT_LIMIT = 20000; // Cycles allowed for any single wait

	logic                 clk = 1'b0;
	logic                 cmd_rst = 1'b1;
	byte_beat_t           rx = '0;
	logic                 rx_credit;
	byte_beat_t           tx;
	logic                 tx_credit = 1'b0;
	logic                 host_rd_req;
	logic                 host_rd_rdy = 1'b0;
	logic                 host_wr_ena;
	logic [ADDR_SIZE-1:0] host_addr;
	logic [7:0]           host_wdata;
	logic [7:0]           host_rdata = 8'h00;
	logic [7:0]           in0 = 8'h00;
	logic [7:0]           in1 = 8'h00;
	logic [7:0]           in2 = 8'h00;
	logic [7:0]           in3 = 8'h00;
	logic [7:0]           out0;
	logic [7:0]           out1;
	logic [7:0]           out2;
	logic [7:0]           out3;

	serial_debugger #(.ADDR_SIZE(ADDR_SIZE), .TX_CREDITS(TX_CREDITS)) dut0 (.*);

	// ********************
	// Shared state
	// ********************
	logic [31:0] rng = 32'd55202;   // Xorshift state
	logic [7:0]  mem [int unsigned]; // Bytes written by the DUT, the rest follow fill_byte
	logic [7:0]  exp_tx [$];         // Bytes the DUT still owes on tx
	int unsigned exp_wr_addr [$];    // Host writes still expected
	logic [7:0]  exp_wr_data [$];
	string       test_name = "reset";
	int          check_errors = 0;
	int          other_errors = 0;
	int          credits_got = 0;    // rx credits returned by the DUT
	int          bytes_sent = 0;     // Bytes put on rx
	int          rd_reqs = 0;        // Host read requests seen
	logic        rd_req_q = 1'b0;    // Read request level one cycle ago
	int          wr_count = 0;       // Host write strobes seen
	int          owed = 0;           // tx credits not yet returned
	int          cr_wait = 0;        // Cycles until the next tx credit may go back
	int          rd_wait = 0;        // Cycles until the memory model answers

	initial begin
		forever #5 clk = ~clk; // 10 ns period
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// Every address bit takes part so misplaced accesses show
	function automatic logic [7:0] fill_byte(input int unsigned a);
		return 8'(a ^ (a >> 8) ^ (a >> 16) ^ 32'h5A);
	endfunction

	function automatic logic [7:0] mem_read(input int unsigned a);
		return mem.exists(a) ? mem[a] : fill_byte(a);
	endfunction

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			check_errors++;
			$display("CHECK FAILED %s %s: expected %02h, actual %02h", test_name, what, exp, act);
		end
	endtask

	task automatic end_run();
		$display("Errors: %0d value mismatches, %0d other failures", check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	task automatic timeout_abort(input string what);
		other_errors++;
		$display("Timeout in %s while waiting for %s", test_name, what);
		end_run();
	endtask

	// ********************
	// Monitors and models
	// ********************
	always @(posedge clk) begin
		if (rx_credit) credits_got++;
		if (host_rd_req && !rd_req_q) rd_reqs++; // Counts each new request
		rd_req_q <= host_rd_req;
		if (tx.valid) begin
			if (exp_tx.size() == 0) begin
				other_errors++;
				$display("Unexpected tx byte %02h in %s", tx.data, test_name);
			end else begin
				check_byte("tx", exp_tx.pop_front(), tx.data);
			end
		end
	end

	// Host writes land in the model and are checked in order
	always @(posedge clk) begin
		if (host_wr_ena) begin
			wr_count++;
			mem[32'(host_addr)] = host_wdata;
			if (exp_wr_addr.size() == 0) begin
				other_errors++;
				$display("Unexpected host write at %05h in %s", host_addr, test_name);
			end else begin
				if (exp_wr_addr[0] != 32'(host_addr)) begin
					check_errors++;
					$display("CHECK FAILED %s write address: expected %05h, actual %05h",
						test_name, exp_wr_addr[0], host_addr);
				end
				check_byte("write data", exp_wr_data[0], host_wdata);
				void'(exp_wr_addr.pop_front());
				void'(exp_wr_data.pop_front());
			end
		end
	end

	// Memory answers a held request after a random delay, ready lasts one cycle
	always @(posedge clk) begin
		if (host_rd_rdy) begin
			host_rd_rdy <= 1'b0;
			rd_wait     = 32'(next_rand() & 32'h3) + 1; // Delay for the next request
		end else if (host_rd_req) begin
			if (rd_wait <= 1) begin
				host_rd_rdy <= 1'b1;
				host_rdata  <= mem_read(32'(host_addr));
			end else begin
				rd_wait--;
			end
		end
	end

	// tx credits go back after short delays, now and then after a long stall
	always @(posedge clk) begin
		logic [31:0] r;
		if (cmd_rst) begin
			owed = 0;
			cr_wait = 0;
			tx_credit <= 1'b0;
		end else begin
			if (tx.valid) owed++;
			if (owed > 0 && cr_wait == 0) begin
				tx_credit <= 1'b1;
				owed--;
				r = next_rand();
				cr_wait = (r[4:0] == 5'd0) ? 40 : 32'(r[1:0]);
			end else begin
				tx_credit <= 1'b0;
				if (cr_wait > 0) cr_wait--;
			end
		end
	end

	// ********************
	// Stimulus tasks
	// ********************
	task automatic send_byte(input logic [7:0] b);
		int t;
		t = 0;
		while (1 + credits_got - bytes_sent <= 0) begin // Host holds one credit after reset
			@(posedge clk);
			t++;
			if (t > WAIT_LIMIT) timeout_abort("an rx credit");
		end
		rx <= '{valid: 1'b1, data: b};
		bytes_sent++;
		@(posedge clk);
		rx <= '{valid: 1'b0, data: 8'h00};
	endtask

	task automatic send_frame(input int n_ff, input logic [63:0] c1, input logic [63:0] c2);
		for (int i = 0; i < n_ff; i++) send_byte(8'hFF);
		for (int i = 0; i < HDR_00_COUNT; i++) send_byte(8'h00);
		for (int i = 7; i >= 0; i--) send_byte(c1[i*8 +: 8]); // Opcode goes first
		for (int i = 7; i >= 0; i--) send_byte(c2[i*8 +: 8]);
	endtask

	task automatic send_cmd(input opcode_e op, input logic [31:0] body);
		send_frame(HDR_FF_COUNT, {op, body}, {op, body});
	endtask

	// Done when every credit is back and nothing is still expected
	task automatic wait_idle();
		int t;
		t = 0;
		while (credits_got != bytes_sent || exp_tx.size() != 0 || exp_wr_addr.size() != 0) begin
			@(posedge clk);
			t++;
			if (t > WAIT_LIMIT) timeout_abort("the operation to finish");
		end
	endtask

	task automatic write_test(input string name, input opcode_e op, input int unsigned addr,
		input logic [7:0] size, input int n);
		logic [7:0] d;
		test_name = name;
		send_cmd(op, {24'(addr), size});
		for (int i = 0; i < n; i++) begin
			d = 8'(next_rand());
			exp_tx.push_back(d); // Echo of each written byte
			exp_wr_addr.push_back((addr + i) & 32'hFFFFF);
			exp_wr_data.push_back(d);
			send_byte(d);
		end
		wait_idle();
	endtask

	task automatic read_test(input string name, input opcode_e op, input int unsigned addr,
		input logic [7:0] size, input int n);
		test_name = name;
		for (int i = 0; i < n; i++) exp_tx.push_back(mem_read((addr + i) & 32'hFFFFF));
		send_cmd(op, {24'(addr), size});
		wait_idle();
	endtask

	// A broken frame must leave memory, tx and ports alone
	task automatic bad_frame_test(input string name, input int n_ff, input logic [63:0] c1,
		input logic [63:0] c2);
		int rd0;
		int wr0;
		logic [31:0] outs0;
		test_name = name;
		rd0 = rd_reqs;
		wr0 = wr_count;
		outs0 = {out0, out1, out2, out3};
		send_frame(n_ff, c1, c2);
		wait_idle();
		for (int i = 0; i < 20; i++) @(posedge clk); // Room for a late command
		if (rd_reqs != rd0 || wr_count != wr0) begin
			other_errors++;
			$display("Host memory was accessed after %s", name);
		end
		if ({out0, out1, out2, out3} != outs0) begin
			other_errors++;
			$display("Output ports changed after %s", name);
		end
	endtask

	initial begin
		for (int i = 0; i < 8; i++) @(posedge clk); // Reset held for 8 cycles
		cmd_rst <= 1'b0;
		@(posedge clk);

		write_test("write_bytes", OP_WRITE_BYTES, 32'h01230, 8'd5, 6);
		read_test("read_back", OP_READ_BYTES, 32'h01230, 8'd5, 6);
		read_test("read_burst", OP_READ_BURST, 32'h0FF80, 8'd0, 256);

		// Set ports returns the inputs, then the address width
		test_name = "set_ports";
		in0 <= 8'hA1;
		in1 <= 8'hB2;
		in2 <= 8'hC3;
		in3 <= 8'hD4;
		exp_tx.push_back(8'hA1);
		exp_tx.push_back(8'hB2);
		exp_tx.push_back(8'hC3);
		exp_tx.push_back(8'hD4);
		exp_tx.push_back(8'(ADDR_SIZE));
		send_cmd(OP_SET_PORTS, 32'h1234_5678);
		@(posedge clk); // Edge that carries cmd_valid and captures the inputs
		in0 <= 8'h1E; // New input values must not reach the status bytes
		in1 <= 8'h2D;
		in2 <= 8'h3C;
		in3 <= 8'h4B;
		wait_idle();
		check_byte("out0", 8'h12, out0);
		check_byte("out1", 8'h34, out1);
		check_byte("out2", 8'h56, out2);
		check_byte("out3", 8'h78, out3);

		bad_frame_test("copy_mismatch", HDR_FF_COUNT, {OP_SET_PORTS, 32'h0102_0304},
			{OP_SET_PORTS, 32'h0102_0305});
		bad_frame_test("short_header", 1, {OP_READ_BYTES, 32'h0000_1003},
			{OP_READ_BYTES, 32'h0000_1003});

		write_test("write_burst", OP_WRITE_BURST, 32'h40000, 8'd0, 256);
		read_test("burst_read_back", OP_READ_BYTES, 32'h40000, 8'd255, 256);
		end_run();
	end

	// Last resort against a stuck run
	initial begin
		for (int i = 0; i < 400000; i++) @(posedge clk);
		timeout_abort("the end of the test");
	end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/dbg_pkg.sv
verilog/cmd_framer.sv
verilog/host_mem_port.sv
verilog/port_bank.sv
verilog/transfer_sequencer.sv
verilog/serial_debugger.sv
tests/serial_debugger_asserts.sv
tests/tb_serial_debugger.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_serial_debugger -o sim_tb

out=$(./obj_dir/sim_tb || true)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
	exit 0
else
	exit 1
fi
